// ==== source/neuronPkg.sv ====
`default_nettype none

package neuronPkg;

    ////////////////////////////////////////////////////////////
    // fixed point format
    ////////////////////////////////////////////////////////////

    // v, u and synaptic current share one word, 2.16 two's complement
    localparam int stateWidth = 18;

    // spike and event counters
    localparam int countWidth = 16;

    ////////////////////////////////////////////////////////////
    // izhikevich constants
    ////////////////////////////////////////////////////////////

    // a = 1/8, b = 1/4 as right shifts
    localparam logic [3:0] shiftA = 4'd3;
    localparam logic [3:0] shiftB = 4'd2;

    // after-spike potential, -0.65
    localparam logic signed [stateWidth-1:0] resetC = 18'sh3_599A;
    // recovery bump per spike, 0.08
    localparam logic signed [stateWidth-1:0] bumpD = 18'sh0_147A;
    // firing level, +0.30
    localparam logic signed [stateWidth-1:0] spikeThreshold = 18'sh0_4CCC;

    // synapse: fixed weight per event, decay by 1/4 per frame
    localparam logic [stateWidth-1:0] synWeight = 18'h0_1000;
    localparam logic [3:0] synTau = 4'd2;

    ////////////////////////////////////////////////////////////
    // slot phases, in the order the sequencer walks them
    ////////////////////////////////////////////////////////////
    localparam logic [1:0] phaseAdvance = 2'd0;
    localparam logic [1:0] phaseRead = 2'd1;
    localparam logic [1:0] phaseCompute = 2'd2;
    localparam logic [1:0] phaseWrite = 2'd3;

endpackage

`default_nettype wire

// ==== source/phaseSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer #(
    parameter int indexWidth = 4
) (
    input wire rawclk,
    input wire rstN,
    input wire [31:0] halfCnt,
    output logic tick,
    output logic [1:0] phase,
    output logic [indexWidth-1:0] neuronIndex,
    output logic frameDone
);

    // delay counter for the tick enable
    logic [31:0] delayCnt;
    // low two bits phase, upper bits neuron index
    logic [indexWidth+1:0] slotCnt;
    // set once the slot counter has wrapped
    logic wrapSeen;

    ////////////////////////////////////////////////////////////
    // tick enable, one cycle every halfCnt+1 cycles
    ////////////////////////////////////////////////////////////
    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            delayCnt <= '0;
            tick <= 1'b0;
        end else if (delayCnt >= halfCnt) begin
            // >= so a smaller halfCnt takes effect at once
            delayCnt <= '0;
            tick <= 1'b1;
        end else begin
            delayCnt <= delayCnt + 32'd1;
            tick <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // slot counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            slotCnt <= '0;
            wrapSeen <= 1'b0;
        end else if (tick) begin
            slotCnt <= slotCnt + 1'b1;
            // last write tick of the pool
            if (&slotCnt) begin
                wrapSeen <= 1'b1;
            end
        end
    end

    assign phase = slotCnt[1:0];
    assign neuronIndex = slotCnt[indexWidth+1:2];

    // advance tick of neuron 0, skipped before the first full frame
    assign frameDone = tick && wrapSeen && (phase == neuronPkg::phaseAdvance)
                       && (neuronIndex == '0);

endmodule

`default_nettype wire

// ==== source/izhNeuronBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module izhNeuronBank #(
    parameter int indexWidth = 4
) (
    input wire rawclk,
    input wire rstN,
    input wire tick,
    input wire [1:0] phase,
    input wire [indexWidth-1:0] neuronIndex,
    input wire signed [neuronPkg::stateWidth-1:0] synCurrent,
    output logic spike,
    output logic spikeValid
);

    localparam int poolSize = 2 ** indexWidth;
    // headroom for 5v and 4v^2 before the step is scaled
    localparam int wideWidth = 26;
    // euler step dt = 1/16
    localparam int dtShift = 4;
    // resting drive 1.40 in 2.16
    localparam logic signed [wideWidth-1:0] restBias = 26'sh1_6666;

    // per-neuron state
    logic signed [neuronPkg::stateWidth-1:0] vMem [poolSize];
    logic signed [neuronPkg::stateWidth-1:0] uMem [poolSize];

    // loaded pair and held input of the current slot
    logic signed [neuronPkg::stateWidth-1:0] vCur;
    logic signed [neuronPkg::stateWidth-1:0] uCur;
    logic signed [neuronPkg::stateWidth-1:0] iHold;

    logic signed [2*neuronPkg::stateWidth-1:0] vSq;
    logic signed [wideWidth-1:0] vWide;
    logic signed [wideWidth-1:0] uWide;
    logic signed [wideWidth-1:0] vDelta;
    logic signed [wideWidth-1:0] uDelta;
    logic signed [wideWidth-1:0] vNext;
    logic signed [wideWidth-1:0] uNext;
    logic fired;
    logic signed [neuronPkg::stateWidth-1:0] vWrite;
    logic signed [neuronPkg::stateWidth-1:0] uWrite;

    ////////////////////////////////////////////////////////////
    // slot load
    ////////////////////////////////////////////////////////////
    always_ff @(posedge rawclk) begin
        if (tick && (phase == neuronPkg::phaseRead)) begin
            vCur <= vMem[neuronIndex];
            uCur <= uMem[neuronIndex];
        end
        // input sampled once, after any event landed at the read tick
        if (tick && (phase == neuronPkg::phaseCompute)) begin
            iHold <= synCurrent;
        end
    end

    ////////////////////////////////////////////////////////////
    // update, v in units of 100 mV
    ////////////////////////////////////////////////////////////
    assign vWide = wideWidth'(vCur);
    assign uWide = wideWidth'(uCur);
    assign vSq = vCur * vCur;

    // 4v^2 + 5v + 1.40 - u + I
    assign vDelta = wideWidth'(vSq >>> 14) + (vWide <<< 2) + vWide + restBias
                    - uWide + wideWidth'(iHold);
    assign vNext = vWide + (vDelta >>> dtShift);

    // a(bv - u)
    assign uDelta = ((vWide >>> neuronPkg::shiftB) - uWide) >>> neuronPkg::shiftA;
    assign uNext = uWide + uDelta;

    assign fired = vNext >= wideWidth'(neuronPkg::spikeThreshold);

    // reset on spike, else keep the integrated pair
    assign vWrite = fired ? neuronPkg::resetC : neuronPkg::stateWidth'(vNext);
    assign uWrite = fired ? neuronPkg::stateWidth'(uNext + wideWidth'(neuronPkg::bumpD))
                          : neuronPkg::stateWidth'(uNext);

    // flagged in the write tick itself
    assign spikeValid = tick && (phase == neuronPkg::phaseWrite);
    assign spike = spikeValid && fired;

    ////////////////////////////////////////////////////////////
    // write back
    ////////////////////////////////////////////////////////////
    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < poolSize; i++) begin
                vMem[i] <= neuronPkg::resetC;
                uMem[i] <= '0;
            end
        end else if (spikeValid) begin
            vMem[neuronIndex] <= vWrite;
            uMem[neuronIndex] <= uWrite;
        end
    end

endmodule

`default_nettype wire

// ==== source/afferentSource.sv ====
`timescale 1ns/1ps
`default_nettype none

module afferentSource #(
    parameter int indexWidth = 4,
    parameter int fifoDepthLog = 2
) (
    input wire rawclk,
    input wire rstN,
    input wire tick,
    input wire [1:0] phase,
    input wire [indexWidth-1:0] neuronIndex,
    input wire [15:0] driveRate,
    input wire [15:0] ppsCoef,
    input wire creditReturn,
    output logic eventPush,
    output logic [indexWidth-1:0] eventIndex,
    output logic [neuronPkg::countWidth-1:0] afferentSpikeCount,
    output logic [neuronPkg::countWidth-1:0] dropCount
);

    // largest positive current, just under 2.0
    localparam logic [31:0] currentMax = 32'h0001_FFFF;
    localparam logic [fifoDepthLog:0] creditInit = (fifoDepthLog+1)'(2 ** fifoDepthLog);

    logic [31:0] driveProduct;
    logic signed [neuronPkg::stateWidth-1:0] driveCurrent;
    logic affSpike;
    logic affValid;
    logic spikeOut;
    // free slots in the event buffer
    logic [fifoDepthLog:0] credits;
    logic hasCredit;

    // drive scaling, product lsb is one current lsb
    assign driveProduct = driveRate * ppsCoef;
    assign driveCurrent = (driveProduct > currentMax)
                          ? neuronPkg::stateWidth'(currentMax)
                          : neuronPkg::stateWidth'(driveProduct);

    izhNeuronBank #(
        .indexWidth(indexWidth)
    ) afferentBank (
        .rawclk(rawclk),
        .rstN(rstN),
        .tick(tick),
        .phase(phase),
        .neuronIndex(neuronIndex),
        .synCurrent(driveCurrent),
        .spike(affSpike),
        .spikeValid(affValid)
    );

    ////////////////////////////////////////////////////////////
    // credit side of the event link
    ////////////////////////////////////////////////////////////
    assign spikeOut = affValid && affSpike;
    assign hasCredit = credits != '0;
    assign eventPush = spikeOut && hasCredit;
    assign eventIndex = neuronIndex;

    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            credits <= creditInit;
        end else if (eventPush && !creditReturn) begin
            credits <= credits - 1'b1;
        end else if (creditReturn && !eventPush) begin
            credits <= credits + 1'b1;
        end
    end

    // spike totals, dropped ones counted apart
    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            afferentSpikeCount <= '0;
            dropCount <= '0;
        end else if (spikeOut) begin
            afferentSpikeCount <= afferentSpikeCount + 1'b1;
            if (!hasCredit) begin
                dropCount <= dropCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/spikeFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module spikeFifo #(
    parameter int indexWidth = 4,
    parameter int fifoDepthLog = 2
) (
    input wire rawclk,
    input wire rstN,
    input wire eventPush,
    input wire [indexWidth-1:0] eventIndex,
    input wire eventPop,
    output logic headValid,
    output logic [indexWidth-1:0] headIndex,
    output logic creditReturn
);

    localparam int depth = 2 ** fifoDepthLog;

    // queued neuron indices
    logic [indexWidth-1:0] slotMem [depth];

    // extra msb tells full from empty
    logic [fifoDepthLog:0] wrPtr;
    logic [fifoDepthLog:0] rdPtr;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // producer holds a credit for every push, so no full check here
    always_ff @(posedge rawclk) begin
        if (eventPush) begin
            slotMem[wrPtr[fifoDepthLog-1:0]] <= eventIndex;
        end
    end

    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (eventPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (eventPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // head and credit
    ////////////////////////////////////////////////////////////
    assign headValid = wrPtr != rdPtr;
    assign headIndex = slotMem[rdPtr[fifoDepthLog-1:0]];

    // one credit back, a cycle after each pop
    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= eventPop;
        end
    end

endmodule

`default_nettype wire

// ==== source/motorPool.sv ====
`timescale 1ns/1ps
`default_nettype none

module motorPool #(
    parameter int indexWidth = 4
) (
    input wire rawclk,
    input wire rstN,
    input wire tick,
    input wire [1:0] phase,
    input wire [indexWidth-1:0] neuronIndex,
    input wire headValid,
    input wire [indexWidth-1:0] headIndex,
    input wire [15:0] mnGain,
    output logic eventPop,
    output logic mnSpike,
    output logic mnSpikeValid,
    output logic [indexWidth-1:0] mnSpikeIndex,
    output logic [neuronPkg::countWidth-1:0] mnSpikeCount,
    output logic [neuronPkg::countWidth-1:0] eventCount
);

    localparam int poolSize = 2 ** indexWidth;
    localparam logic [33:0] currentMax = 34'h0_0001_FFFF;

    // synaptic current per motoneuron, never negative
    logic [neuronPkg::stateWidth-1:0] synMem [poolSize];

    logic [neuronPkg::stateWidth-1:0] indexCurrent;
    logic [33:0] gainProduct;
    logic signed [neuronPkg::stateWidth-1:0] mnCurrent;

    ////////////////////////////////////////////////////////////
    // event delivery
    ////////////////////////////////////////////////////////////

    // head waits until its own neuron comes round
    assign eventPop = tick && (phase == neuronPkg::phaseRead) && headValid
                      && (headIndex == neuronIndex);

    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < poolSize; i++) begin
                synMem[i] <= '0;
            end
        end else if (eventPop) begin
            // at most one event per slot, so the sum stays small
            synMem[neuronIndex] <= synMem[neuronIndex] + neuronPkg::synWeight;
        end else if (tick && (phase == neuronPkg::phaseWrite)) begin
            // decay once per frame
            synMem[neuronIndex] <= synMem[neuronIndex]
                                   - (synMem[neuronIndex] >> neuronPkg::synTau);
        end
    end

    ////////////////////////////////////////////////////////////
    // motoneurons
    ////////////////////////////////////////////////////////////
    assign indexCurrent = synMem[neuronIndex];
    assign gainProduct = indexCurrent * mnGain;
    // saturate to positive range
    assign mnCurrent = (gainProduct > currentMax)
                       ? neuronPkg::stateWidth'(currentMax)
                       : neuronPkg::stateWidth'(gainProduct);

    izhNeuronBank #(
        .indexWidth(indexWidth)
    ) motorBank (
        .rawclk(rawclk),
        .rstN(rstN),
        .tick(tick),
        .phase(phase),
        .neuronIndex(neuronIndex),
        .synCurrent(mnCurrent),
        .spike(mnSpike),
        .spikeValid(mnSpikeValid)
    );

    assign mnSpikeIndex = neuronIndex;

    // spike and delivery totals
    always_ff @(posedge rawclk or negedge rstN) begin
        if (!rstN) begin
            mnSpikeCount <= '0;
            eventCount <= '0;
        end else begin
            if (mnSpike) begin
                mnSpikeCount <= mnSpikeCount + 1'b1;
            end
            if (eventPop) begin
                eventCount <= eventCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/neuronPool.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronPool #(
    parameter int indexWidth = 4,
    parameter int fifoDepthLog = 2
) (
    input wire rawclk,
    input wire rstN,
    input wire [31:0] halfCnt,
    input wire [15:0] driveRate,
    input wire [15:0] ppsCoef,
    input wire [15:0] mnGain,
    output logic mnSpike,
    output logic mnSpikeValid,
    output logic [indexWidth-1:0] mnSpikeIndex,
    output logic frameDone,
    output logic [neuronPkg::countWidth-1:0] afferentSpikeCount,
    output logic [neuronPkg::countWidth-1:0] mnSpikeCount,
    output logic [neuronPkg::countWidth-1:0] eventCount,
    output logic [neuronPkg::countWidth-1:0] dropCount
);

    // slot timing shared by both banks
    logic tick;
    logic [1:0] phase;
    logic [indexWidth-1:0] neuronIndex;

    // event link
    logic eventPush;
    logic [indexWidth-1:0] eventIndex;
    logic eventPop;
    logic headValid;
    logic [indexWidth-1:0] headIndex;
    logic creditReturn;

    phaseSequencer #(
        .indexWidth(indexWidth)
    ) sequencer (
        .rawclk(rawclk),
        .rstN(rstN),
        .halfCnt(halfCnt),
        .tick(tick),
        .phase(phase),
        .neuronIndex(neuronIndex),
        .frameDone(frameDone)
    );

    ////////////////////////////////////////////////////////////
    // afferent pool, event buffer, motor pool
    ////////////////////////////////////////////////////////////
    afferentSource #(
        .indexWidth(indexWidth),
        .fifoDepthLog(fifoDepthLog)
    ) afferent (
        .rawclk(rawclk),
        .rstN(rstN),
        .tick(tick),
        .phase(phase),
        .neuronIndex(neuronIndex),
        .driveRate(driveRate),
        .ppsCoef(ppsCoef),
        .creditReturn(creditReturn),
        .eventPush(eventPush),
        .eventIndex(eventIndex),
        .afferentSpikeCount(afferentSpikeCount),
        .dropCount(dropCount)
    );

    spikeFifo #(
        .indexWidth(indexWidth),
        .fifoDepthLog(fifoDepthLog)
    ) eventBuffer (
        .rawclk(rawclk),
        .rstN(rstN),
        .eventPush(eventPush),
        .eventIndex(eventIndex),
        .eventPop(eventPop),
        .headValid(headValid),
        .headIndex(headIndex),
        .creditReturn(creditReturn)
    );

    motorPool #(
        .indexWidth(indexWidth)
    ) motor (
        .rawclk(rawclk),
        .rstN(rstN),
        .tick(tick),
        .phase(phase),
        .neuronIndex(neuronIndex),
        .headValid(headValid),
        .headIndex(headIndex),
        .mnGain(mnGain),
        .eventPop(eventPop),
        .mnSpike(mnSpike),
        .mnSpikeValid(mnSpikeValid),
        .mnSpikeIndex(mnSpikeIndex),
        .mnSpikeCount(mnSpikeCount),
        .eventCount(eventCount)
    );

endmodule

`default_nettype wire

// ==== sim/neuronPoolTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronPoolTb;

    localparam int indexWidth = 4;
    localparam int poolSize = 2 ** indexWidth;
    localparam int slotsPerFrame = 4 * poolSize;
    localparam int numRows = 5;
    // frames allowed for the afferent pool to fall silent
    localparam int drainLimit = 20;

    logic rawclk;
    logic rstN;
    logic [31:0] halfCnt;
    logic [15:0] driveRate;
    logic [15:0] ppsCoef;
    logic [15:0] mnGain;

    wire mnSpike;
    wire mnSpikeValid;
    wire [indexWidth-1:0] mnSpikeIndex;
    wire frameDone;
    wire [neuronPkg::countWidth-1:0] afferentSpikeCount;
    wire [neuronPkg::countWidth-1:0] mnSpikeCount;
    wire [neuronPkg::countWidth-1:0] eventCount;
    wire [neuronPkg::countWidth-1:0] dropCount;

    // row layout, msb first
    // halfCnt 32, driveRate 16, ppsCoef 16, mnGain 16, frames 16,
    // afferent spikes expected, motor spikes expected
    logic [97:0] stimTable [numRows];

    // slot order monitor
    int frameCount;
    int pulsesInFrame;
    logic [indexWidth-1:0] nextIndex;
    // cycles since the last write slot
    int cyclesSinceWrite;
    // fired flags seen on the motoneuron write slots
    int mnSpikesSeen;

    neuronPool #(
        .indexWidth(indexWidth),
        .fifoDepthLog(2)
    ) neuronPool_inst (
        .rawclk(rawclk),
        .rstN(rstN),
        .halfCnt(halfCnt),
        .driveRate(driveRate),
        .ppsCoef(ppsCoef),
        .mnGain(mnGain),
        .mnSpike(mnSpike),
        .mnSpikeValid(mnSpikeValid),
        .mnSpikeIndex(mnSpikeIndex),
        .frameDone(frameDone),
        .afferentSpikeCount(afferentSpikeCount),
        .mnSpikeCount(mnSpikeCount),
        .eventCount(eventCount),
        .dropCount(dropCount)
    );

    // 10 ns clock
    initial begin
        rawclk = 1'b0;
        forever begin
            #5 rawclk = ~rawclk;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // one cycle, outputs looked at on the falling edge
    task automatic stepCycle();
        @(negedge rawclk);
        if (mnSpike) begin
            // fired flag only rides on a write slot
            checkValue("mnSpikeValid with mnSpike", mnSpikeValid, 1);
            mnSpikesSeen++;
        end
        if (mnSpikeValid) begin
            // write slots walk the pool in order
            checkValue("mnSpikeIndex", mnSpikeIndex, nextIndex);
            nextIndex = nextIndex + 1'b1;
            pulsesInFrame++;
            cyclesSinceWrite = 0;
        end else begin
            cyclesSinceWrite++;
        end
        if (frameDone) begin
            checkValue("mnSpikeValid pulses per frame", pulsesInFrame, poolSize);
            // one tick after the write slot of the last neuron
            checkValue("cycles from last write slot to frameDone", cyclesSinceWrite,
                       int'(halfCnt) + 1);
            pulsesInFrame = 0;
            frameCount++;
        end
    endtask

    task automatic runFrames(input int frames, input int rowNum);
        int startFrame;
        int cycles;
        int limit;
        startFrame = frameCount;
        cycles = 0;
        limit = (frames + 2) * slotsPerFrame * (int'(halfCnt) + 1) + 100;
        while (frameCount - startFrame < frames) begin
            if (cycles >= limit) begin
                abortRun($sformatf("timeout in row %0d, only %0d of %0d frames seen",
                                   rowNum, frameCount - startFrame, frames));
            end
            stepCycle();
            cycles++;
        end
    endtask

    // reset with the row inputs already applied
    task automatic startRow(input logic [97:0] row);
        @(negedge rawclk);
        rstN = 1'b0;
        halfCnt = row[97:66];
        driveRate = row[65:50];
        ppsCoef = row[49:34];
        mnGain = row[33:18];
        repeat (10) @(negedge rawclk);
        rstN = 1'b1;
        frameCount = 0;
        pulsesInFrame = 0;
        nextIndex = '0;
        cyclesSinceWrite = 0;
        mnSpikesSeen = 0;
    endtask

    task automatic checkStartState();
        checkValue("afferentSpikeCount", afferentSpikeCount, 0);
        checkValue("mnSpikeCount", mnSpikeCount, 0);
        checkValue("eventCount", eventCount, 0);
        checkValue("dropCount", dropCount, 0);
        // no write slot before the first tick
        for (int c = 0; c <= int'(halfCnt); c++) begin
            checkValue("mnSpikeValid", mnSpikeValid, 0);
            stepCycle();
        end
    endtask

    // drive already off, wait until two frames pass with no new afferent spike
    task automatic drainEvents(input int rowNum);
        int quietFrames;
        int waited;
        int lastCount;
        quietFrames = 0;
        waited = 0;
        lastCount = afferentSpikeCount;
        while (quietFrames < 2) begin
            if (waited >= drainLimit) begin
                abortRun($sformatf("row %0d: afferent spikes kept coming with zero drive",
                                   rowNum));
            end
            runFrames(1, rowNum);
            waited++;
            if (int'(afferentSpikeCount) == lastCount) begin
                quietFrames++;
            end else begin
                quietFrames = 0;
            end
            lastCount = afferentSpikeCount;
        end
    endtask

    task automatic fillTable();
        // silent pool, strong drive, no motor gain, then two more tick rates
        stimTable[0] = {32'd0, 16'h0000, 16'h0100, 16'hFFFF, 16'd20, 1'b0, 1'b0};
        stimTable[1] = {32'd0, 16'h0200, 16'h0100, 16'hFFFF, 16'd40, 1'b1, 1'b1};
        stimTable[2] = {32'd2, 16'h0200, 16'h0100, 16'h0000, 16'd30, 1'b1, 1'b0};
        stimTable[3] = {32'd1, 16'h0080, 16'h0300, 16'h0800, 16'd50, 1'b1, 1'b1};
        stimTable[4] = {32'd3, 16'h0040, 16'h0400, 16'h0800, 16'd40, 1'b1, 1'b1};
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus loop
    ////////////////////////////////////////////////////////////
    initial begin
        logic [97:0] row;
        int runLength;
        logic affExpect;
        logic mnExpect;
        int delivered;
        rstN = 1'b0;
        halfCnt = '0;
        driveRate = '0;
        ppsCoef = '0;
        mnGain = '0;
        frameCount = 0;
        pulsesInFrame = 0;
        nextIndex = '0;
        cyclesSinceWrite = 0;
        mnSpikesSeen = 0;
        fillTable();
        for (int r = 0; r < numRows; r++) begin
            row = stimTable[r];
            runLength = int'(row[17:2]);
            affExpect = row[1];
            mnExpect = row[0];
            startRow(row);
            checkStartState();
            runFrames(runLength, r);

            // zero or nonzero classes
            checkValue("afferentSpikeCount nonzero", afferentSpikeCount != 0, affExpect);
            checkValue("eventCount nonzero", eventCount != 0, affExpect);
            checkValue("mnSpikeCount nonzero", mnSpikeCount != 0, mnExpect);
            checkValue("mnSpike pulses nonzero", mnSpikesSeen != 0, mnExpect);

            // every afferent spike is either delivered or dropped
            driveRate = '0;
            drainEvents(r);
            delivered = int'(eventCount) + int'(dropCount);
            checkValue("eventCount + dropCount", delivered, afferentSpikeCount);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/neuronPkg.sv
source/phaseSequencer.sv
source/izhNeuronBank.sv
source/afferentSource.sv
source/spikeFifo.sv
source/motorPool.sv
source/neuronPool.sv
sim/neuronPoolTb.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it, look for the pass line
verilator --binary --timing -Wno-fatal -f build.f --top-module neuronPoolTb -o simNeuronPool \
    && ./obj_dir/simNeuronPool | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
